/* hdl/cache_pkg.sv */
// geometry and shared types of the 2-way write-through cache
// front-end addresses are byte addresses; the two low bits are ignored
package cache_pkg;

   localparam int ADDR_W        = 16;
   localparam int DATA_W        = 32;
   localparam int NBYTES        = 4;
   localparam int NBYTES_W      = 2;
   localparam int WORD_OFFSET_W = 2;
   localparam int NWORDS        = 2 ** WORD_OFFSET_W;
   localparam int NLINES_W      = 4;
   localparam int NLINES        = 2 ** NLINES_W;
   localparam int NWAYS_W       = 1;
   localparam int NWAYS         = 2 ** NWAYS_W;
   localparam int TAG_W         = ADDR_W - NBYTES_W - WORD_OFFSET_W - NLINES_W;
   localparam int WTBUF_DEPTH_W = 2;
   localparam int WTBUF_DEPTH   = 2 ** WTBUF_DEPTH_W;
   // word and line address widths
   localparam int WADDR_W       = ADDR_W - NBYTES_W;
   localparam int LADDR_W       = WADDR_W - WORD_OFFSET_W;

   typedef logic [DATA_W-1:0]        word_t;
   typedef logic [TAG_W-1:0]         tag_t;
   typedef logic [NBYTES-1:0]        strb_t;
   typedef logic [WADDR_W-1:0]       waddr_t;
   typedef logic [NLINES_W-1:0]      index_t;
   typedef logic [WORD_OFFSET_W-1:0] offset_t;
   typedef logic [NWAYS-1:0]         way_vec_t;
   typedef logic [NWAYS_W-1:0]       way_idx_t;

   // every word of the addressed set, all ways
   typedef word_t [NWAYS-1:0][NWORDS-1:0] line_words_t;

   typedef struct packed {
      waddr_t addr;
      word_t  wdata;
      strb_t  wstrb;
   } fe_req_t;

   typedef struct packed {
      waddr_t addr;
      word_t  wdata;
      strb_t  wstrb;
   } wt_entry_t;

   ////////////////////
   // address fields
   ////////////////////
   function automatic tag_t tag_of(waddr_t a);
      return a[WADDR_W-1 -: TAG_W];
   endfunction

   function automatic index_t index_of(waddr_t a);
      return a[WORD_OFFSET_W +: NLINES_W];
   endfunction

   function automatic offset_t offset_of(waddr_t a);
      return a[WORD_OFFSET_W-1:0];
   endfunction

   // one-hot way vector to way number, zero when nothing is set
   function automatic way_idx_t way_index(way_vec_t hit);
      way_idx_t idx;
      idx = '0;
      for (int k = 0; k < NWAYS; k++) begin
         if (hit[k]) begin
            idx = way_idx_t'(k);
         end
      end
      return idx;
   endfunction

endpackage

/* hdl/cache_sp_ram.sv */
// single-port RAM with one registered read per enabled cycle
// write-first: a write also shows the new word on d_o
module cache_sp_ram #(
   parameter type payload_t = logic [31:0]
) (
   input  logic              clk_i,
   input  logic              en_i,
   input  logic              we_i,
   input  cache_pkg::index_t addr_i,
   input  payload_t          d_i,
   output payload_t          d_o
);

   payload_t mem [cache_pkg::NLINES];

   always_ff @(posedge clk_i) begin
      if (en_i) begin
         if (we_i) begin
            mem[addr_i] <= d_i;
            d_o         <= d_i;
         end else begin
            d_o <= mem[addr_i];
         end
      end
   end

endmodule

/* hdl/cache_tag_lookup.sv */
// decode stage; tag RAMs and valid outputs are read from the live address
// so they line up with the request registered on the same edge
module cache_tag_lookup (
   input  logic                        clk_i,
   input  logic                        arst_i,
   input  logic                        req_i,
   input  logic [cache_pkg::ADDR_W-1:0] addr_i,
   input  cache_pkg::word_t            wdata_i,
   input  cache_pkg::strb_t            wstrb_i,
   input  logic                        invalidate_i,
   input  logic                        replace_i,
   input  logic                        ack_i,
   input  logic                        replace_req_i,
   input  cache_pkg::way_vec_t         victim_i,
   output cache_pkg::fe_req_t          req_q_o,
   output logic                        req_valid_o,
   output cache_pkg::way_vec_t         way_hit_o,
   output logic                        raw_o
);

   cache_pkg::waddr_t   waddr;
   cache_pkg::index_t   index;
   cache_pkg::fe_req_t  req_q;
   logic                req_valid_q;
   logic [cache_pkg::NWAYS-1:0][cache_pkg::NLINES-1:0] valid_q;
   cache_pkg::way_vec_t valid_rd_q;
   cache_pkg::tag_t     tag_rd [cache_pkg::NWAYS];
   cache_pkg::way_vec_t way_hit;
   logic                write_access;
   logic                read_access;
   logic                wr_hit_prev_q;
   cache_pkg::way_vec_t way_prev_q;
   cache_pkg::offset_t  offset_prev_q;

   assign waddr = addr_i[cache_pkg::ADDR_W-1:cache_pkg::NBYTES_W];
   assign index = cache_pkg::index_of(waddr);

   // request is taken every cycle, valid drops for one cycle after the ack
   always_ff @(posedge clk_i) begin
      req_q <= '{addr: waddr, wdata: wdata_i, wstrb: wstrb_i};
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         req_valid_q <= 1'b0;
      end else begin
         req_valid_q <= req_i & ~ack_i;
      end
   end

   ////////////////////
   // valid bits
   ////////////////////
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         valid_q    <= '0;
         valid_rd_q <= '0;
      end else if (invalidate_i) begin
         valid_q    <= '0;
         valid_rd_q <= '0;
      end else begin
         // the victim way takes the missing line
         for (int k = 0; k < cache_pkg::NWAYS; k++) begin
            if (replace_req_i && victim_i[k]) begin
               valid_q[k][cache_pkg::index_of(req_q.addr)] <= 1'b1;
            end
            if (req_i) begin
               valid_rd_q[k] <= valid_q[k][index];
            end
         end
      end
   end

   for (genvar k = 0; k < cache_pkg::NWAYS; k++) begin : g_tag_way
      cache_sp_ram #(
         .payload_t(cache_pkg::tag_t)
      ) u_tag_ram (
         .clk_i (clk_i),
         .en_i  (req_i),
         .we_i  (replace_req_i & victim_i[k]),
         .addr_i(index),
         .d_i   (cache_pkg::tag_of(req_q.addr)),
         .d_o   (tag_rd[k])
      );

      assign way_hit[k] = valid_rd_q[k] & (tag_rd[k] == cache_pkg::tag_of(req_q.addr));
   end

   ////////////////////
   // read-after-write
   ////////////////////
   assign write_access = req_valid_q & (|req_q.wstrb);
   assign read_access  = req_valid_q & ~(|req_q.wstrb);

   // history of the last real access, held over idle cycles and refills
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_hit_prev_q <= 1'b0;
      end else if (req_valid_q && !replace_i) begin
         wr_hit_prev_q <= write_access & (|way_hit);
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_valid_q && !replace_i) begin
         way_prev_q    <= way_hit;
         offset_prev_q <= cache_pkg::offset_of(req_q.addr);
      end
   end

   assign raw_o = read_access & wr_hit_prev_q & (way_prev_q == way_hit) &
                  (offset_prev_q == cache_pkg::offset_of(req_q.addr));

   assign req_q_o     = req_q;
   assign req_valid_o = req_valid_q;
   assign way_hit_o   = way_hit;

endmodule

/* hdl/cache_lru.sv */
// one bit per set naming the least recently used of two ways
// only acks that hit a way move the bit
module cache_lru (
   input  logic                clk_i,
   input  logic                arst_i,
   input  logic                invalidate_i,
   input  logic                update_i,
   input  cache_pkg::index_t   index_i,
   input  cache_pkg::way_vec_t way_hit_i,
   output cache_pkg::way_vec_t victim_o
);

   cache_pkg::way_idx_t lru_q [cache_pkg::NLINES];
   cache_pkg::way_idx_t used_way;

   assign used_way = cache_pkg::way_index(way_hit_i);

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         lru_q <= '{default: '0};
      end else if (invalidate_i) begin
         lru_q <= '{default: '0};
      end else if (update_i && (|way_hit_i)) begin
         // the other way becomes the oldest
         lru_q[index_i] <= ~used_way;
      end
   end

   assign victim_o = cache_pkg::way_vec_t'(1) << lru_q[index_i];

endmodule

/* hdl/cache_data_store.sv */
// execute stage; one word RAM per way and word offset
// byte writes are merged with the word already on the RAM output
module cache_data_store (
   input  logic                         clk_i,
   input  logic                         req_i,
   input  logic [cache_pkg::ADDR_W-1:0] addr_i,
   input  cache_pkg::fe_req_t           req_q_i,
   input  cache_pkg::way_vec_t          way_hit_i,
   input  cache_pkg::way_vec_t          victim_i,
   input  logic                         write_hit_i,
   input  logic                         replace_i,
   input  logic                         read_req_i,
   input  cache_pkg::offset_t           read_addr_i,
   input  cache_pkg::word_t             read_rdata_i,
   output cache_pkg::line_words_t       line_o
);

   cache_pkg::index_t index;
   cache_pkg::word_t  src;
   cache_pkg::strb_t  be      [cache_pkg::NWAYS][cache_pkg::NWORDS];
   cache_pkg::word_t  wr_word [cache_pkg::NWAYS][cache_pkg::NWORDS];

   assign index = cache_pkg::index_of(addr_i[cache_pkg::ADDR_W-1:cache_pkg::NBYTES_W]);
   assign src   = replace_i ? read_rdata_i : req_q_i.wdata;

   ////////////////////
   // byte enables
   ////////////////////
   always_comb begin
      for (int k = 0; k < cache_pkg::NWAYS; k++) begin
         for (int j = 0; j < cache_pkg::NWORDS; j++) begin
            be[k][j] = '0;
            if (replace_i) begin
               // refill fills the victim way word by word
               if (read_req_i && victim_i[k] && read_addr_i == cache_pkg::offset_t'(j)) begin
                  be[k][j] = '1;
               end
            end else if (write_hit_i && way_hit_i[k] &&
                         cache_pkg::offset_of(req_q_i.addr) == cache_pkg::offset_t'(j)) begin
               be[k][j] = req_q_i.wstrb;
            end
            for (int b = 0; b < cache_pkg::NBYTES; b++) begin
               wr_word[k][j][8*b +: 8] = be[k][j][b] ? src[8*b +: 8] : line_o[k][j][8*b +: 8];
            end
         end
      end
   end

   for (genvar k = 0; k < cache_pkg::NWAYS; k++) begin : g_way
      for (genvar j = 0; j < cache_pkg::NWORDS; j++) begin : g_word
         cache_sp_ram #(
            .payload_t(cache_pkg::word_t)
         ) u_data_ram (
            .clk_i (clk_i),
            .en_i  (req_i),
            .we_i  (|be[k][j]),
            .addr_i(index),
            .d_i   (wr_word[k][j]),
            .d_o   (line_o[k][j])
         );
      end
   end

endmodule

/* hdl/cache_write_buffer.sv */
// write-through FIFO of four register entries
// a push into a full buffer is taken only when a pop happens in the same cycle
module cache_write_buffer (
   input  logic                 clk_i,
   input  logic                 arst_i,
   input  logic                 push_i,
   input  cache_pkg::wt_entry_t entry_i,
   input  logic                 pop_i,
   output cache_pkg::wt_entry_t head_o,
   output logic                 empty_o,
   output logic                 full_o
);

   cache_pkg::wt_entry_t mem_q [cache_pkg::WTBUF_DEPTH];
   logic [cache_pkg::WTBUF_DEPTH_W-1:0] wr_ptr_q;
   logic [cache_pkg::WTBUF_DEPTH_W-1:0] rd_ptr_q;
   logic [cache_pkg::WTBUF_DEPTH_W:0]   count_q;
   logic do_push;
   logic do_pop;

   assign empty_o = (count_q == '0);
   assign full_o  = (count_q == cache_pkg::WTBUF_DEPTH);
   assign do_pop  = pop_i & ~empty_o;
   assign do_push = push_i & (~full_o | do_pop);

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem_q[wr_ptr_q] <= entry_i;
      end
   end

   ////////////////////
   // pointers and level
   ////////////////////
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   assign head_o = mem_q[rd_ptr_q];

endmodule

/* hdl/cache_response.sv */
// result stage; ack, read data and miss request from the lookup result
// a miss waits for an empty write buffer so the back end holds every write
module cache_response (
   input  cache_pkg::fe_req_t     req_q_i,
   input  logic                   req_valid_i,
   input  cache_pkg::way_vec_t    way_hit_i,
   input  logic                   raw_i,
   input  logic                   replace_i,
   input  cache_pkg::line_words_t line_i,
   input  logic                   buf_full_i,
   input  logic                   buf_empty_i,
   input  logic                   write_ack_i,
   output logic                   ack_o,
   output cache_pkg::word_t       rdata_o,
   output logic                   replace_req_o,
   output logic                   read_hit_o,
   output logic                   read_miss_o,
   output logic                   write_hit_o
);

   logic read_access;
   logic write_access;
   logic hit;

   assign write_access = req_valid_i & (|req_q_i.wstrb);
   assign read_access  = req_valid_i & ~(|req_q_i.wstrb);

   // data is on the RAM outputs only outside a refill and a hazard
   assign hit = (|way_hit_i) & ~replace_i & ~raw_i;

   // a pop in the same cycle frees a slot in a full buffer
   assign ack_o = (read_access & hit) | (write_access & (~buf_full_i | write_ack_i));

   assign replace_req_o = read_access & ~(|way_hit_i) & ~replace_i & buf_empty_i;

   assign rdata_o = line_i[cache_pkg::way_index(way_hit_i)][cache_pkg::offset_of(req_q_i.addr)];

   assign read_hit_o  = ack_o & read_access;
   assign read_miss_o = replace_req_o;
   assign write_hit_o = ack_o & write_access & hit;

endmodule

/* hdl/cache_memory.sv */
// 2-way write-through cache core, no write allocate
// the back end must raise replace_i the cycle after replace_req_o
// and keep it high until the last refill word is written
module cache_memory (
   input  logic                          clk_i,
   input  logic                          arst_i,
   // front end
   input  logic                          req_i,
   input  logic [cache_pkg::ADDR_W-1:0]  addr_i,
   input  cache_pkg::word_t              wdata_i,
   input  cache_pkg::strb_t              wstrb_i,
   output logic                          ack_o,
   output cache_pkg::word_t              rdata_o,
   // back-end read
   output logic                          replace_req_o,
   output logic [cache_pkg::LADDR_W-1:0] replace_addr_o,
   input  logic                          replace_i,
   input  logic                          read_req_i,
   input  cache_pkg::offset_t            read_addr_i,
   input  cache_pkg::word_t              read_rdata_i,
   // back-end write
   output logic                          write_req_o,
   output cache_pkg::waddr_t             write_addr_o,
   output cache_pkg::word_t              write_wdata_o,
   output cache_pkg::strb_t              write_wstrb_o,
   input  logic                          write_ack_i,
   // control and status
   input  logic                          invalidate_i,
   output logic                          wtbuf_full_o,
   output logic                          wtbuf_empty_o,
   output logic                          read_hit_o,
   output logic                          read_miss_o,
   output logic                          write_hit_o
);

   cache_pkg::fe_req_t     req_q;
   logic                   req_valid;
   cache_pkg::way_vec_t    way_hit;
   cache_pkg::way_vec_t    victim;
   logic                   raw;
   cache_pkg::line_words_t line;
   logic                   wt_push;
   cache_pkg::wt_entry_t   wt_entry;
   cache_pkg::wt_entry_t   wt_head;

   cache_tag_lookup u_tag_lookup (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .req_i        (req_i),
      .addr_i       (addr_i),
      .wdata_i      (wdata_i),
      .wstrb_i      (wstrb_i),
      .invalidate_i (invalidate_i),
      .replace_i    (replace_i),
      .ack_i        (ack_o),
      .replace_req_i(replace_req_o),
      .victim_i     (victim),
      .req_q_o      (req_q),
      .req_valid_o  (req_valid),
      .way_hit_o    (way_hit),
      .raw_o        (raw)
   );

   cache_lru u_lru (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .invalidate_i(invalidate_i),
      .update_i    (ack_o),
      .index_i     (cache_pkg::index_of(req_q.addr)),
      .way_hit_i   (way_hit),
      .victim_o    (victim)
   );

   cache_data_store u_data_store (
      .clk_i       (clk_i),
      .req_i       (req_i),
      .addr_i      (addr_i),
      .req_q_i     (req_q),
      .way_hit_i   (way_hit),
      .victim_i    (victim),
      .write_hit_i (write_hit_o),
      .replace_i   (replace_i),
      .read_req_i  (read_req_i),
      .read_addr_i (read_addr_i),
      .read_rdata_i(read_rdata_i),
      .line_o      (line)
   );

   // every acked write goes to the back end
   assign wt_push  = ack_o & (|req_q.wstrb);
   assign wt_entry = '{addr: req_q.addr, wdata: req_q.wdata, wstrb: req_q.wstrb};

   cache_write_buffer u_write_buffer (
      .clk_i  (clk_i),
      .arst_i (arst_i),
      .push_i (wt_push),
      .entry_i(wt_entry),
      .pop_i  (write_ack_i),
      .head_o (wt_head),
      .empty_o(wtbuf_empty_o),
      .full_o (wtbuf_full_o)
   );

   cache_response u_response (
      .req_q_i      (req_q),
      .req_valid_i  (req_valid),
      .way_hit_i    (way_hit),
      .raw_i        (raw),
      .replace_i    (replace_i),
      .line_i       (line),
      .buf_full_i   (wtbuf_full_o),
      .buf_empty_i  (wtbuf_empty_o),
      .write_ack_i  (write_ack_i),
      .ack_o        (ack_o),
      .rdata_o      (rdata_o),
      .replace_req_o(replace_req_o),
      .read_hit_o   (read_hit_o),
      .read_miss_o  (read_miss_o),
      .write_hit_o  (write_hit_o)
   );

   assign replace_addr_o = req_q.addr[cache_pkg::WADDR_W-1:cache_pkg::WORD_OFFSET_W];
   assign write_req_o    = ~wtbuf_empty_o;
   assign write_addr_o   = wt_head.addr;
   assign write_wdata_o  = wt_head.wdata;
   assign write_wstrb_o  = wt_head.wstrb;

endmodule

/* verification/cache_checker.sv */
// watches the front end and the write port of the cache core
// the shadow must hold the back-end contents before reset is released
module cache_checker (
   input  logic                         clk_i,
   input  logic                         arst_i,
   input  logic                         req_i,
   input  logic [cache_pkg::ADDR_W-1:0] addr_i,
   input  cache_pkg::word_t             wdata_i,
   input  cache_pkg::strb_t             wstrb_i,
   input  logic                         ack_i,
   input  cache_pkg::word_t             rdata_i,
   input  logic                         write_req_i,
   input  cache_pkg::waddr_t            write_addr_i,
   input  cache_pkg::word_t             write_wdata_i,
   input  cache_pkg::strb_t             write_wstrb_i,
   input  logic                         write_ack_i,
   output int                           errors_o,
   output int                           checks_o,
   output int                           pending_o
);

   // memory as the front end sees it
   cache_pkg::word_t     shadow [2 ** cache_pkg::WADDR_W];
   // acked writes not yet seen on the write port
   cache_pkg::wt_entry_t sent_q [$];

   function automatic cache_pkg::word_t merge_bytes(cache_pkg::word_t old_w,
                                                    cache_pkg::word_t new_w,
                                                    cache_pkg::strb_t strb);
      cache_pkg::word_t w;
      w = old_w;
      for (int b = 0; b < cache_pkg::NBYTES; b++) begin
         if (strb[b]) begin
            w[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return w;
   endfunction

   // expected read data for a word address
   function automatic cache_pkg::word_t expected_word(cache_pkg::waddr_t a);
      return shadow[a];
   endfunction

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks_o++;
      if (got !== exp) begin
         errors_o++;
         $display("FAILED t=%0t %s: got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   initial begin
      errors_o  = 0;
      checks_o  = 0;
      pending_o = 0;
   end

   ////////////////////
   // compare on edges
   ////////////////////
   always @(posedge clk_i) begin : watch
      cache_pkg::waddr_t    waddr;
      cache_pkg::wt_entry_t head;
      waddr = addr_i[cache_pkg::ADDR_W-1:cache_pkg::NBYTES_W];
      if (!arst_i) begin
         // pop before push, both can happen on one edge
         if (write_req_i && write_ack_i) begin
            if (sent_q.size() == 0) begin
               errors_o++;
               $display("the write port sent a write at %0t that was never issued", $time);
            end else begin
               head = sent_q.pop_front();
               compare("write_addr_o", write_addr_i, head.addr);
               compare("write_wdata_o", write_wdata_i, head.wdata);
               compare("write_wstrb_o", write_wstrb_i, head.wstrb);
            end
         end
         if (req_i && ack_i) begin
            if (wstrb_i != '0) begin
               shadow[waddr] = merge_bytes(shadow[waddr], wdata_i, wstrb_i);
               sent_q.push_back(cache_pkg::wt_entry_t'{addr: waddr, wdata: wdata_i,
                                                       wstrb: wstrb_i});
            end else begin
               compare("rdata_o", rdata_i, expected_word(waddr));
            end
         end
         pending_o = sent_q.size();
      end
   end

endmodule

/* verification/cache_memory_tb.sv */
// testbench for the cache core with a random back-end memory behind it
// the back end raises replace_i one cycle after replace_req_o and refills in rotated order
// test 4 relies on the write-ack model being held off while the buffer fills
module cache_memory_tb;

   localparam int CLK_PERIOD = 4;
   localparam int MEM_WORDS  = 2 ** cache_pkg::WADDR_W;
   // watchdog budget, front-end requests times the worst cycles per request
   localparam int TOTAL_REQS = 70;
   localparam int WORST_REQ  = 40;
   // expected miss pattern of the A B A C A B sequence, bit n for access n
   localparam logic [5:0] LRU_MISS = 6'b101011;

   typedef logic [cache_pkg::ADDR_W-1:0] fe_addr_t;

   logic                          clk_i;
   logic                          arst_i;
   logic                          req_i;
   fe_addr_t                      addr_i;
   cache_pkg::word_t              wdata_i;
   cache_pkg::strb_t              wstrb_i;
   logic                          ack_o;
   cache_pkg::word_t              rdata_o;
   logic                          replace_req_o;
   logic [cache_pkg::LADDR_W-1:0] replace_addr_o;
   logic                          replace_i;
   logic                          read_req_i;
   cache_pkg::offset_t            read_addr_i;
   cache_pkg::word_t              read_rdata_i;
   logic                          write_req_o;
   cache_pkg::waddr_t             write_addr_o;
   cache_pkg::word_t              write_wdata_o;
   cache_pkg::strb_t              write_wstrb_o;
   logic                          write_ack_i;
   logic                          invalidate_i;
   logic                          wtbuf_full_o;
   logic                          wtbuf_empty_o;
   logic                          read_hit_o;
   logic                          read_miss_o;
   logic                          write_hit_o;

   cache_pkg::word_t backend_mem [MEM_WORDS];
   logic             hold_write_ack;
   int               tb_errors;
   int               tb_checks;
   int               test_num;
   int               tests_failed;
   int               errors_before;
   int               chk_errors;
   int               chk_checks;
   int               chk_pending;

   cache_memory UUT (.*);

   cache_checker u_checker (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .req_i        (req_i),
      .addr_i       (addr_i),
      .wdata_i      (wdata_i),
      .wstrb_i      (wstrb_i),
      .ack_i        (ack_o),
      .rdata_i      (rdata_o),
      .write_req_i  (write_req_o),
      .write_addr_i (write_addr_o),
      .write_wdata_i(write_wdata_o),
      .write_wstrb_i(write_wstrb_o),
      .write_ack_i  (write_ack_i),
      .errors_o     (chk_errors),
      .checks_o     (chk_checks),
      .pending_o    (chk_pending)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   ////////////////////
   // back-end model
   ////////////////////
   always begin : refill
      cache_pkg::offset_t first;
      cache_pkg::offset_t off;
      @(posedge clk_i);
      if (replace_req_o) begin
         #1;
         replace_i = 1'b1;
         first = cache_pkg::offset_t'($urandom_range(3));
         for (int w = 0; w < cache_pkg::NWORDS; w++) begin
            off = first + cache_pkg::offset_t'(w);
            @(posedge clk_i);
            #1;
            read_req_i   = 1'b1;
            read_addr_i  = off;
            read_rdata_i = backend_mem[{replace_addr_o, off}];
            @(posedge clk_i);
            #1;
            read_req_i = 1'b0;
         end
         replace_i = 1'b0;
      end
   end

   // pops the head after a random gap and applies it to memory
   always begin : drain
      int unsigned gap;
      @(posedge clk_i);
      if (write_req_o && !hold_write_ack) begin
         gap = $urandom_range(3);
         repeat (gap) @(posedge clk_i);
         #1;
         write_ack_i = 1'b1;
         for (int b = 0; b < cache_pkg::NBYTES; b++) begin
            if (write_wstrb_o[b]) begin
               backend_mem[write_addr_o][8*b +: 8] = write_wdata_o[8*b +: 8];
            end
         end
         @(posedge clk_i);
         #1;
         write_ack_i = 1'b0;
      end
   end

   ////////////////////
   // helpers
   ////////////////////
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Simulation finished: FAIL");
      $finish;
   endtask

   function automatic fe_addr_t make_addr(cache_pkg::tag_t tag, cache_pkg::index_t index,
                                          cache_pkg::offset_t offset);
      return {tag, index, offset, 2'b00};
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      tb_checks++;
      if (got !== exp) begin
         tb_errors++;
         $display("FAILED t=%0t %s: got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic drive_request(input fe_addr_t addr, input cache_pkg::word_t wdata,
                                input cache_pkg::strb_t wstrb);
      @(posedge clk_i);
      #1;
      req_i   = 1'b1;
      addr_i  = addr;
      wdata_i = wdata;
      wstrb_i = wstrb;
   endtask

   // collects the event strobes until the ack, then drops the request
   task automatic await_ack(output logic saw_hit, output logic saw_miss,
                            output logic saw_wr_hit);
      saw_hit    = 1'b0;
      saw_miss   = 1'b0;
      saw_wr_hit = 1'b0;
      do begin
         @(posedge clk_i);
         saw_hit    |= read_hit_o;
         saw_miss   |= read_miss_o;
         saw_wr_hit |= write_hit_o;
      end while (!ack_o);
      #1;
      req_i = 1'b0;
   endtask

   task automatic read_word(input fe_addr_t addr, output logic saw_hit, output logic saw_miss);
      logic unused_wr_hit;
      drive_request(addr, '0, '0);
      await_ack(saw_hit, saw_miss, unused_wr_hit);
   endtask

   task automatic write_word(input fe_addr_t addr, input cache_pkg::word_t wdata,
                             input cache_pkg::strb_t wstrb, output logic saw_wr_hit);
      logic unused_hit;
      logic unused_miss;
      drive_request(addr, wdata, wstrb);
      await_ack(unused_hit, unused_miss, saw_wr_hit);
   endtask

   task automatic wait_empty();
      while (!wtbuf_empty_o) begin
         @(posedge clk_i);
      end
   endtask

   task automatic close_test(input string name);
      int errs;
      errs = tb_errors + chk_errors - errors_before;
      test_num++;
      if (errs == 0) begin
         $display("test %0d %s: ok", test_num, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", test_num, name, errs);
      end
      errors_before = tb_errors + chk_errors;
   endtask

   initial begin : watchdog
      #(CLK_PERIOD * (TOTAL_REQS * WORST_REQ + 500));
      abort_run("watchdog expired before the tests completed");
   end

   ////////////////////
   // stimulus
   ////////////////////
   initial begin : stimulus
      logic             hit;
      logic             miss;
      logic             wr_hit;
      logic             acked;
      fe_addr_t         a;
      cache_pkg::word_t v;
      cache_pkg::tag_t  line_tag [8];
      cache_pkg::tag_t  seq_tag [6];
      int               k;
      void'($urandom(32'he5a57ff1));
      clk_i          = 1'b0;
      arst_i         = 1'b1;
      req_i          = 1'b0;
      addr_i         = '0;
      wdata_i        = '0;
      wstrb_i        = '0;
      replace_i      = 1'b0;
      read_req_i     = 1'b0;
      read_addr_i    = '0;
      read_rdata_i   = '0;
      write_ack_i    = 1'b0;
      invalidate_i   = 1'b0;
      hold_write_ack = 1'b0;
      tb_errors      = 0;
      tb_checks      = 0;
      test_num       = 0;
      tests_failed   = 0;
      errors_before  = 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         v = $urandom;
         backend_mem[i]      = v;
         u_checker.shadow[i] = v;
      end
      repeat (5) @(posedge clk_i);
      #1;
      arst_i = 1'b0;

      // one line in each of sets 0 to 7, so nothing is evicted
      for (int i = 0; i < 8; i++) begin
         line_tag[i] = cache_pkg::tag_t'($urandom);
      end
      for (int n = 0; n < 24; n++) begin
         k = (n < 8) ? n : $urandom_range(7);
         a = make_addr(line_tag[k], cache_pkg::index_t'(k), cache_pkg::offset_t'($urandom));
         read_word(a, hit, miss);
         check_bit("read_miss_o", miss, n < 8);
         check_bit("read_hit_o", hit, 1'b1);
      end
      close_test("random reads");

      // write hit then the same word at once, the hazard case
      for (int n = 0; n < 8; n++) begin
         a = make_addr(line_tag[n], cache_pkg::index_t'(n), cache_pkg::offset_t'($urandom));
         write_word(a, $urandom, cache_pkg::strb_t'($urandom_range(15, 1)), wr_hit);
         check_bit("write_hit_o", wr_hit, 1'b1);
         read_word(a, hit, miss);
         check_bit("read_miss_o", miss, 1'b0);
      end
      // no write allocate, so the read refills from the back end
      a = make_addr(line_tag[0] ^ 8'h80, '0, 2'd1);
      write_word(a, $urandom, 4'b0110, wr_hit);
      check_bit("write_hit_o", wr_hit, 1'b0);
      read_word(a, hit, miss);
      check_bit("read_miss_o", miss, 1'b1);
      close_test("write then read");

      for (int n = 0; n < 12; n++) begin
         write_word(fe_addr_t'($urandom), $urandom, cache_pkg::strb_t'($urandom_range(15, 1)),
                    wr_hit);
      end
      wait_empty();
      tb_checks++;
      if (chk_pending != 0) begin
         tb_errors++;
         $display("%0d acked writes never appeared on the write port", chk_pending);
      end
      close_test("write-through order");

      wait_empty();
      hold_write_ack = 1'b1;
      for (int n = 0; n < cache_pkg::WTBUF_DEPTH; n++) begin
         write_word(fe_addr_t'($urandom), $urandom, 4'hf, wr_hit);
      end
      check_bit("wtbuf_full_o", wtbuf_full_o, 1'b1);
      drive_request(fe_addr_t'($urandom), $urandom, 4'b1001);
      acked = 1'b0;
      repeat (10) begin
         @(posedge clk_i);
         acked |= ack_o;
      end
      check_bit("ack_o", acked, 1'b0);
      check_bit("wtbuf_full_o", wtbuf_full_o, 1'b1);
      #1;
      hold_write_ack = 1'b0;
      await_ack(hit, miss, wr_hit);
      wait_empty();
      tb_checks++;
      if (chk_pending != 0) begin
         tb_errors++;
         $display("%0d held writes never appeared on the write port", chk_pending);
      end
      close_test("buffer back-pressure");

      a = make_addr(line_tag[3], 4'd3, 2'd2);
      read_word(a, hit, miss);
      check_bit("read_miss_o", miss, 1'b0);
      @(posedge clk_i);
      #1;
      invalidate_i = 1'b1;
      @(posedge clk_i);
      #1;
      invalidate_i = 1'b0;
      read_word(a, hit, miss);
      check_bit("read_miss_o", miss, 1'b1);
      close_test("invalidate");

      // A B A C in set 9, then A stays and B is gone
      seq_tag = '{8'h11, 8'h22, 8'h11, 8'h33, 8'h11, 8'h22};
      for (int n = 0; n < 6; n++) begin
         read_word(make_addr(seq_tag[n], 4'd9, cache_pkg::offset_t'(n)), hit, miss);
         check_bit("read_miss_o", miss, LRU_MISS[n]);
      end
      close_test("lru victim");

      $display("%0d tests run, %0d failed, %0d checks, %0d errors", test_num, tests_failed,
               tb_checks + chk_checks, tb_errors + chk_errors);
      if (tb_errors + chk_errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* files.f */
hdl/cache_pkg.sv
hdl/cache_sp_ram.sv
hdl/cache_tag_lookup.sv
hdl/cache_lru.sv
hdl/cache_data_store.sv
hdl/cache_write_buffer.sv
hdl/cache_response.sv
hdl/cache_memory.sv
verification/cache_checker.sv
verification/cache_memory_tb.sv

/* Bender.yml */
package:
  name: cache_memory

sources:
  - hdl/cache_pkg.sv
  - hdl/cache_sp_ram.sv
  - hdl/cache_tag_lookup.sv
  - hdl/cache_lru.sv
  - hdl/cache_data_store.sv
  - hdl/cache_write_buffer.sv
  - hdl/cache_response.sv
  - hdl/cache_memory.sv
  - target: any(test, simulation)
    files:
      - verification/cache_checker.sv
      - verification/cache_memory_tb.sv
